/* filelist.f */
+incdir+common
common/cpuPkg.sv
datapath/RegisterFile.sv
datapath/Alu.sv
datapath/BranchCondition.sv
datapath/DataPath.sv
control/ControlUnit.sv
hw/Memory.sv
hw/Cpu.sv
verif/Cpu_assertions.sv
verif/CpuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module CpuTb -o CpuTbSim > build.log 2>&1 \
	&& ./obj_dir/CpuTbSim > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -q "All checks passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* verif/CpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module CpuTb import cpuPkg::*; ();

	logic                    clock = 1'b0;
	logic                    rst;
	logic                    loadEn;
	logic [`ADDR_WIDTH-1:0]  loadAddr;
	logic [`DATA_WIDTH-1:0]  loadData;
	logic [`DATA_WIDTH-1:0]  inPort;
	logic [`DATA_WIDTH-1:0]  outPort;
	logic                    halted;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] lfsr = 32'd46;

	// Program image, queued inputs, captured and expected outputs
	logic [31:0] progWords [$];
	logic [31:0] inWords [$];
	logic [31:0] outWords [$];
	logic [31:0] expWords [$];

	always #4 clock = ~clock;

	Cpu Cpu_inst (
		.clock    (clock),
		.rst      (rst),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.inPort   (inPort),
		.outPort  (outPort),
		.halted   (halted)
	);

	// Six programs of at most about 40 instructions, plus load and reset
	always @(posedge clock) begin
		cycles++;
		if (cycles >= 4000) begin
			$display("Timeout: halted never rose within 4000 cycles");
			$display("Checks failed");
			$finish;
		end
	end

	function logic nextLfsrBit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'hA3000000;
		end
		return b;
	endfunction

	function logic [31:0] randomWord();
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			w = {w[30:0], nextLfsrBit()};
		end
		return w;
	endfunction

	// Instruction encoders
	function logic [31:0] rWord(opcode_t op, logic [3:0] ra, logic [3:0] rb, logic [3:0] rc);
		return {op, ra, rb, rc, 15'd0};
	endfunction

	function logic [31:0] iWord(opcode_t op, logic [3:0] ra, logic [3:0] rb, int c);
		return {op, ra, rb, c[18:0]};
	endfunction

	function logic [31:0] signExtend19(int c);
		return {{13{c[18]}}, c[18:0]};
	endfunction

	task check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	// Hold reset, download, run until halted while capturing every out
	task runProgram();
		logic pending;
		rst = 1'b1;
		repeat (8) @(posedge clock);
		for (int i = 0; i < progWords.size(); i++) begin
			#1;
			loadEn   = 1'b1;
			loadAddr = i[`ADDR_WIDTH-1:0];
			loadData = progWords[i];
			@(posedge clock);
		end
		#1;
		// Previous run left outPort and halted set
		check("outPort after reset", outPort, 32'd0);
		check("halted after reset", halted, 32'd0);
		loadEn = 1'b0;
		inPort = (inWords.size() > 0) ? inWords.pop_front() : '0;
		outWords.delete();
		pending = 1'b0;
		rst = 1'b0;
		while (!halted) begin
			@(posedge clock);
			#1;
			if (pending) begin
				outWords.push_back(outPort);
				pending = 1'b0;
			end
			// Next operand goes in while the out step runs
			if (Cpu_inst.ControlUnit_inst.outportIn) begin
				pending = 1'b1;
				if (inWords.size() > 0) begin
					inPort = inWords.pop_front();
				end
			end
		end
	endtask

	task compareOutputs(input string test);
		check({test, " outCount"}, outWords.size(), expWords.size());
		for (int i = 0; i < expWords.size() && i < outWords.size(); i++) begin
			check($sformatf("%s outPort[%0d]", test, i), outWords[i], expWords[i]);
		end
	endtask

	task arithmeticOps();
		logic [31:0] a;
		logic [31:0] b;
		a = randomWord();
		b = randomWord();
		progWords = '{rWord(opIn, 1, 0, 0), rWord(opOut, 1, 0, 0), rWord(opIn, 2, 0, 0),
			rWord(opAdd, 3, 1, 2), rWord(opOut, 3, 0, 0), rWord(opSub, 3, 1, 2),
			rWord(opOut, 3, 0, 0), rWord(opAnd, 3, 1, 2), rWord(opOut, 3, 0, 0),
			rWord(opOr, 3, 1, 2), rWord(opOut, 3, 0, 0), rWord(opShl, 3, 1, 2),
			rWord(opOut, 3, 0, 0), rWord(opShr, 3, 1, 2), rWord(opOut, 3, 0, 0),
			rWord(opHalt, 0, 0, 0)};
		inWords = '{a, b};
		expWords = '{a, a + b, a - b, a & b, a | b, a << b[4:0], a >> b[4:0]};
		runProgram();
		compareOutputs("arith");
	endtask

	task immediateLoads();
		progWords = '{iWord(opLdi, 1, 0, -5), rWord(opOut, 1, 0, 0),
			iWord(opAddi, 2, 1, -300), rWord(opOut, 2, 0, 0),
			iWord(opLdi, 3, 0, 32'h3FFFF), rWord(opOut, 3, 0, 0),
			iWord(opLdi, 4, 0, 32'h40000), rWord(opOut, 4, 0, 0),
			iWord(opLdi, 6, 1, -1), rWord(opOut, 6, 0, 0), rWord(opHalt, 0, 0, 0)};
		inWords.delete();
		expWords = '{signExtend19(-5), signExtend19(-5) + signExtend19(-300),
			32'h0003FFFF, signExtend19(32'h40000), signExtend19(-5) + 32'hFFFFFFFF};
		runProgram();
		compareOutputs("imm");
	endtask

	task memoryRoundTrip();
		logic [31:0] v;
		v = randomWord();
		// R0 is written nonzero before it serves as a base
		progWords = '{rWord(opIn, 1, 0, 0), rWord(opOut, 1, 0, 0),
			iWord(opLdi, 2, 0, 100), iWord(opSt, 1, 2, 5), iWord(opLd, 3, 2, 5),
			rWord(opOut, 3, 0, 0), iWord(opLdi, 0, 0, 7), rWord(opOut, 0, 0, 0),
			iWord(opLd, 4, 0, 105), rWord(opOut, 4, 0, 0), iWord(opSt, 0, 0, 200),
			iWord(opLd, 5, 0, 200), rWord(opOut, 5, 0, 0), rWord(opHalt, 0, 0, 0)};
		inWords = '{v};
		expWords = '{v, v, 32'd7, v, 32'd7};
		runProgram();
		compareOutputs("mem");
	endtask

	task signedMultiply();
		logic [31:0]        a;
		logic [31:0]        b;
		logic signed [63:0] p;
		a = randomWord();
		b = randomWord();
		p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
		progWords = '{rWord(opIn, 1, 0, 0), rWord(opOut, 1, 0, 0), rWord(opIn, 2, 0, 0),
			rWord(opMul, 1, 2, 0), rWord(opMfhi, 3, 0, 0), rWord(opOut, 3, 0, 0),
			rWord(opMflo, 4, 0, 0), rWord(opOut, 4, 0, 0), rWord(opHalt, 0, 0, 0)};
		inWords = '{a, b};
		expWords = '{a, p[63:32], p[31:0]};
		runProgram();
		compareOutputs("mul");
	endtask

	task branchConditions();
		int      vals [8];
		brCond_t conds [8];
		logic    taken;
		vals = '{0, 5, 5, 0, 3, -3, -4, 0};
		conds = '{condZero, condZero, condNonzero, condNonzero,
			condPositive, condPositive, condNegative, condNegative};
		progWords = '{iWord(opLdi, 10, 0, 32'hA)};
		expWords.delete();
		for (int i = 0; i < 8; i++) begin
			// Taken branch skips the not-taken marker
			progWords.push_back(iWord(opLdi, 1, 0, vals[i]));
			progWords.push_back(iWord(opBr, 1, 4'(conds[i]), 1));
			progWords.push_back(rWord(opOut, 10, 0, 0));
			progWords.push_back(iWord(opLdi, 11, 0, i + 1));
			progWords.push_back(rWord(opOut, 11, 0, 0));
			case (conds[i])
				condZero:     taken = (vals[i] == 0);
				condNonzero:  taken = (vals[i] != 0);
				condPositive: taken = (vals[i] > 0);
				default:      taken = (vals[i] < 0);
			endcase
			if (!taken) begin
				expWords.push_back(32'hA);
			end
			expWords.push_back(i + 1);
		end
		progWords.push_back(rWord(opHalt, 0, 0, 0));
		inWords.delete();
		runProgram();
		compareOutputs("branch");
	endtask

	task callReturn();
		int jalAddr;
		jalAddr = 2;
		progWords = '{iWord(opLdi, 1, 0, 10), iWord(opLdi, 2, 0, 32'h11),
			rWord(opJal, 1, 0, 0), rWord(opOut, 15, 0, 0), iWord(opLdi, 2, 0, 32'h33),
			rWord(opOut, 2, 0, 0), rWord(opHalt, 0, 0, 0), rWord(opHalt, 0, 0, 0),
			rWord(opHalt, 0, 0, 0), rWord(opHalt, 0, 0, 0), rWord(opOut, 2, 0, 0),
			rWord(opJr, 15, 0, 0)};
		inWords.delete();
		expWords = '{32'h11, jalAddr + 1, 32'h33};
		runProgram();
		compareOutputs("call");
	endtask

	initial begin
		rst      = 1'b1;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		inPort   = '0;
		arithmeticOps();
		immediateLoads();
		memoryRoundTrip();
		signedMultiply();
		branchConditions();
		callReturn();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/Cpu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module CpuAssertions (
	input wire        clock,
	input wire        rst,
	input wire [8:0]  busSel,
	input wire [28:0] strobes,
	input wire        halted
);

	// Register read and base read count as one source
	busOneSource: assert property (@(posedge clock) disable iff (rst) $onehot0(busSel))
		else $error("more than one bus source selected");

	haltedHolds: assert property (@(posedge clock) $fell(halted) |-> $past(rst))
		else $error("halted fell without reset");

	quietAfterReset: assert property (@(posedge clock) $past(rst) |-> strobes == '0)
		else $error("strobe active in the cycle after reset");

endmodule

bind ControlUnit CpuAssertions controlChecks (
	.clock   (clock),
	.rst     (rst),
	.busSel  ({hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut, rOut | baOut}),
	.strobes ({irIn, pcIn, ryIn, rzIn, marIn, mdrIn, hiIn, loIn, outportIn, hiOut, loOut,
		zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut, gra, grb, grc, rIn, rOut, baOut,
		conIn, incPc, jumpLink, memRead, memWrite, halted}),
	.halted  (halted)
);

`default_nettype wire

/* hw/Cpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module Cpu import cpuPkg::*; (
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    loadEn,
	input  logic [`ADDR_WIDTH-1:0]  loadAddr,
	input  logic [`DATA_WIDTH-1:0]  loadData,
	input  logic [`DATA_WIDTH-1:0]  inPort,
	output logic [`DATA_WIDTH-1:0]  outPort,
	output logic                    halted
);

	logic irIn, pcIn, ryIn, rzIn, marIn, mdrIn, hiIn, loIn, outportIn;
	logic hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut;
	logic gra, grb, grc, rIn, rOut, baOut;
	logic conIn, incPc, jumpLink, memRead, memWrite, conBit;
	opcode_t                 aluOp;
	instrWord_t              irData;
	logic [`ADDR_WIDTH-1:0]  memAddr;
	logic [`DATA_WIDTH-1:0]  memWriteData;
	logic [`DATA_WIDTH-1:0]  memReadData;

	ControlUnit ControlUnit_inst (
		.clock(clock), .rst(rst), .irData(irData), .conBit(conBit),
		.irIn(irIn), .pcIn(pcIn), .ryIn(ryIn), .rzIn(rzIn), .marIn(marIn),
		.mdrIn(mdrIn), .hiIn(hiIn), .loIn(loIn), .outportIn(outportIn),
		.hiOut(hiOut), .loOut(loOut), .zHiOut(zHiOut), .zLoOut(zLoOut),
		.pcOut(pcOut), .mdrOut(mdrOut), .inportOut(inportOut), .cOut(cOut),
		.gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut), .baOut(baOut),
		.conIn(conIn), .incPc(incPc), .jumpLink(jumpLink), .memRead(memRead),
		.memWrite(memWrite), .aluOp(aluOp), .halted(halted)
	);

	DataPath DataPath_inst (
		.clock(clock), .rst(rst),
		.irIn(irIn), .pcIn(pcIn), .ryIn(ryIn), .rzIn(rzIn), .marIn(marIn),
		.mdrIn(mdrIn), .hiIn(hiIn), .loIn(loIn), .outportIn(outportIn),
		.hiOut(hiOut), .loOut(loOut), .zHiOut(zHiOut), .zLoOut(zLoOut),
		.pcOut(pcOut), .mdrOut(mdrOut), .inportOut(inportOut), .cOut(cOut),
		.gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut), .baOut(baOut),
		.conIn(conIn), .incPc(incPc), .jumpLink(jumpLink), .memRead(memRead),
		.aluOp(aluOp), .memReadData(memReadData), .inPort(inPort),
		.memAddr(memAddr), .memWriteData(memWriteData), .outPort(outPort),
		.irData(irData), .conBit(conBit)
	);

	Memory Memory_inst (
		.clock(clock), .addr(memAddr), .writeData(memWriteData), .write(memWrite),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.readData(memReadData)
	);

endmodule

`default_nettype wire

/* hw/Memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module Memory (
	input  logic                    clock,
	input  logic [`ADDR_WIDTH-1:0]  addr,
	input  logic [`DATA_WIDTH-1:0]  writeData,
	input  logic                    write,
	input  logic                    loadEn,
	input  logic [`ADDR_WIDTH-1:0]  loadAddr,
	input  logic [`DATA_WIDTH-1:0]  loadData,
	output logic [`DATA_WIDTH-1:0]  readData
);

	logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

	always_ff @(posedge clock) begin
		// Program download wins over a CPU store
		if (loadEn) begin
			mem[loadAddr] <= loadData;
		end else if (write) begin
			mem[addr] <= writeData;
		end
		readData <= mem[addr];
	end

endmodule

`default_nettype wire

/* control/ControlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

// Execute steps per opcode
//   ld ra,C(rb)     5   st ra,C(rb)    5
//   ldi ra,C(rb)    3   alu ra,rb,rc   3   addi ra,rb,C  3
//   mul ra,rb       4   br ra,C        4
//   jal ra          2   others         1
module ControlUnit import cpuPkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  instrWord_t  irData,
	input  logic        conBit,
	output logic        irIn,
	output logic        pcIn,
	output logic        ryIn,
	output logic        rzIn,
	output logic        marIn,
	output logic        mdrIn,
	output logic        hiIn,
	output logic        loIn,
	output logic        outportIn,
	output logic        hiOut,
	output logic        loOut,
	output logic        zHiOut,
	output logic        zLoOut,
	output logic        pcOut,
	output logic        mdrOut,
	output logic        inportOut,
	output logic        cOut,
	output logic        gra,
	output logic        grb,
	output logic        grc,
	output logic        rIn,
	output logic        rOut,
	output logic        baOut,
	output logic        conIn,
	output logic        incPc,
	output logic        jumpLink,
	output logic        memRead,
	output logic        memWrite,
	output opcode_t     aluOp,
	output logic        halted
);

	typedef enum logic [1:0] {sIdle, sFetch, sExec, sHalt} state_t;

	state_t      state;
	logic [2:0]  step;
	logic [2:0]  lastStep;
	opcode_t     op;

	assign op = irData.rFormat.opcode;

	always_comb begin
		case (op)
			opLd, opSt: lastStep = 3'd4;
			opLdi, opAdd, opSub, opAnd, opOr, opShl, opShr, opAddi: lastStep = 3'd2;
			opMul, opBr: lastStep = 3'd3;
			opJal: lastStep = 3'd1;
			default: lastStep = 3'd0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= sIdle;
			step  <= '0;
		end else begin
			case (state)
				sIdle: begin
					state <= sFetch;
					step  <= '0;
				end
				sFetch: begin
					if (step == 3'd2) begin
						state <= sExec;
						step  <= '0;
					end else begin
						step <= step + 3'd1;
					end
				end
				sExec: begin
					if (step == lastStep) begin
						state <= (op == opHalt) ? sHalt : sFetch;
						step  <= '0;
					end else begin
						step <= step + 3'd1;
					end
				end
				default: ;
			endcase
		end
	end

	assign halted = (state == sHalt);

	always_comb begin
		irIn      = 1'b0;
		pcIn      = 1'b0;
		ryIn      = 1'b0;
		rzIn      = 1'b0;
		marIn     = 1'b0;
		mdrIn     = 1'b0;
		hiIn      = 1'b0;
		loIn      = 1'b0;
		outportIn = 1'b0;
		hiOut     = 1'b0;
		loOut     = 1'b0;
		zHiOut    = 1'b0;
		zLoOut    = 1'b0;
		pcOut     = 1'b0;
		mdrOut    = 1'b0;
		inportOut = 1'b0;
		cOut      = 1'b0;
		gra       = 1'b0;
		grb       = 1'b0;
		grc       = 1'b0;
		rIn       = 1'b0;
		rOut      = 1'b0;
		baOut     = 1'b0;
		conIn     = 1'b0;
		incPc     = 1'b0;
		jumpLink  = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		aluOp     = opAdd;

		if (state == sFetch) begin
			case (step)
				3'd0: begin
					pcOut = 1'b1;
					marIn = 1'b1;
					incPc = 1'b1;
					rzIn  = 1'b1;
				end
				3'd1: begin
					zLoOut  = 1'b1;
					pcIn    = 1'b1;
					memRead = 1'b1;
					mdrIn   = 1'b1;
				end
				default: begin
					mdrOut = 1'b1;
					irIn   = 1'b1;
				end
			endcase
		end else if (state == sExec) begin
			case (op)
				opLd, opLdi, opSt: begin
					case (step)
						3'd0: begin
							grb   = 1'b1;
							baOut = 1'b1;
							ryIn  = 1'b1;
						end
						3'd1: begin
							cOut = 1'b1;
							rzIn = 1'b1;
						end
						3'd2: begin
							zLoOut = 1'b1;
							gra    = (op == opLdi);
							rIn    = (op == opLdi);
							marIn  = (op != opLdi);
						end
						3'd3: begin
							// ld keeps the address on the bus while MDR takes memory
							zLoOut  = (op == opLd);
							memRead = (op == opLd);
							gra     = (op == opSt);
							rOut    = (op == opSt);
							mdrIn   = 1'b1;
						end
						default: begin
							mdrOut   = 1'b1;
							gra      = (op == opLd);
							rIn      = (op == opLd);
							memWrite = (op == opSt);
						end
					endcase
				end
				opAdd, opSub, opAnd, opOr, opShl, opShr, opAddi: begin
					case (step)
						3'd0: begin
							grb  = 1'b1;
							rOut = 1'b1;
							ryIn = 1'b1;
						end
						3'd1: begin
							cOut  = (op == opAddi);
							grc   = (op != opAddi);
							rOut  = (op != opAddi);
							rzIn  = 1'b1;
							aluOp = op;
						end
						default: begin
							zLoOut = 1'b1;
							gra    = 1'b1;
							rIn    = 1'b1;
						end
					endcase
				end
				opMul: begin
					case (step)
						3'd0: begin
							gra  = 1'b1;
							rOut = 1'b1;
							ryIn = 1'b1;
						end
						3'd1: begin
							grb   = 1'b1;
							rOut  = 1'b1;
							rzIn  = 1'b1;
							aluOp = opMul;
						end
						3'd2: begin
							zLoOut = 1'b1;
							loIn   = 1'b1;
						end
						default: begin
							zHiOut = 1'b1;
							hiIn   = 1'b1;
						end
					endcase
				end
				opBr: begin
					case (step)
						3'd0: begin
							gra   = 1'b1;
							rOut  = 1'b1;
							conIn = 1'b1;
						end
						3'd1: begin
							pcOut = 1'b1;
							ryIn  = 1'b1;
						end
						3'd2: begin
							cOut = 1'b1;
							rzIn = 1'b1;
						end
						default: begin
							// Target is PC plus constant, taken only on a set condition
							zLoOut = 1'b1;
							pcIn   = conBit;
						end
					endcase
				end
				opJal: begin
					if (step == 3'd0) begin
						pcOut    = 1'b1;
						jumpLink = 1'b1;
					end else begin
						gra  = 1'b1;
						rOut = 1'b1;
						pcIn = 1'b1;
					end
				end
				opJr: begin
					gra  = 1'b1;
					rOut = 1'b1;
					pcIn = 1'b1;
				end
				opIn: begin
					inportOut = 1'b1;
					gra       = 1'b1;
					rIn       = 1'b1;
				end
				opOut: begin
					gra       = 1'b1;
					rOut      = 1'b1;
					outportIn = 1'b1;
				end
				opMfhi: begin
					hiOut = 1'b1;
					gra   = 1'b1;
					rIn   = 1'b1;
				end
				opMflo: begin
					loOut = 1'b1;
					gra   = 1'b1;
					rIn   = 1'b1;
				end
				opHalt: pcOut = 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* datapath/DataPath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module DataPath import cpuPkg::*; (
	input  logic                     clock,
	input  logic                     rst,
	// Register enables
	input  logic                     irIn,
	input  logic                     pcIn,
	input  logic                     ryIn,
	input  logic                     rzIn,
	input  logic                     marIn,
	input  logic                     mdrIn,
	input  logic                     hiIn,
	input  logic                     loIn,
	input  logic                     outportIn,
	// Bus source selects
	input  logic                     hiOut,
	input  logic                     loOut,
	input  logic                     zHiOut,
	input  logic                     zLoOut,
	input  logic                     pcOut,
	input  logic                     mdrOut,
	input  logic                     inportOut,
	input  logic                     cOut,
	// Register field controls
	input  logic                     gra,
	input  logic                     grb,
	input  logic                     grc,
	input  logic                     rIn,
	input  logic                     rOut,
	input  logic                     baOut,
	input  logic                     conIn,
	input  logic                     incPc,
	input  logic                     jumpLink,
	input  logic                     memRead,
	input  opcode_t                  aluOp,
	input  logic [`DATA_WIDTH-1:0]   memReadData,
	input  logic [`DATA_WIDTH-1:0]   inPort,
	output logic [`ADDR_WIDTH-1:0]   memAddr,
	output logic [`DATA_WIDTH-1:0]   memWriteData,
	output logic [`DATA_WIDTH-1:0]   outPort,
	output instrWord_t               irData,
	output logic                     conBit
);

	instrWord_t                ir;
	logic [`DATA_WIDTH-1:0]    pc;
	logic [`DATA_WIDTH-1:0]    ry;
	logic [`DATA_WIDTH-1:0]    rzHi;
	logic [`DATA_WIDTH-1:0]    rzLo;
	logic [`ADDR_WIDTH-1:0]    mar;
	logic [`DATA_WIDTH-1:0]    mdr;
	logic [`DATA_WIDTH-1:0]    hi;
	logic [`DATA_WIDTH-1:0]    lo;
	logic [`DATA_WIDTH-1:0]    inReg;
	logic [`DATA_WIDTH-1:0]    outReg;
	logic [`DATA_WIDTH-1:0]    bus;
	logic [`DATA_WIDTH-1:0]    regOut;
	logic [`DATA_WIDTH-1:0]    cSignExt;
	logic [2*`DATA_WIDTH-1:0]  aluResult;

	// Constant field extended from bit 18
	assign cSignExt = {{(`DATA_WIDTH-19){ir.iFormat.constant[18]}}, ir.iFormat.constant};

	// One source drives the bus per step
	always_comb begin
		case (1'b1)
			hiOut:        bus = hi;
			loOut:        bus = lo;
			zHiOut:       bus = rzHi;
			zLoOut:       bus = rzLo;
			pcOut:        bus = pc;
			mdrOut:       bus = mdr;
			inportOut:    bus = inReg;
			cOut:         bus = cSignExt;
			rOut, baOut:  bus = regOut;
			default:      bus = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ir     <= '0;
			pc     <= '0;
			ry     <= '0;
			rzHi   <= '0;
			rzLo   <= '0;
			mar    <= '0;
			mdr    <= '0;
			hi     <= '0;
			lo     <= '0;
			inReg  <= '0;
			outReg <= '0;
		end else begin
			if (irIn)      ir   <= bus;
			if (pcIn)      pc   <= bus;
			if (ryIn)      ry   <= bus;
			if (marIn)     mar  <= bus[`ADDR_WIDTH-1:0];
			if (hiIn)      hi   <= bus;
			if (loIn)      lo   <= bus;
			if (outportIn) outReg <= bus;
			if (rzIn) begin
				rzHi <= aluResult[2*`DATA_WIDTH-1:`DATA_WIDTH];
				rzLo <= aluResult[`DATA_WIDTH-1:0];
			end
			// MDR takes memory data on a read, the bus otherwise
			if (mdrIn) mdr <= memRead ? memReadData : bus;
			// Input port sampled every cycle
			inReg <= inPort;
		end
	end

	// Memory latches its read address on the same edge as MAR
	assign memAddr      = marIn ? bus[`ADDR_WIDTH-1:0] : mar;
	assign memWriteData = mdr;
	assign outPort      = outReg;
	assign irData       = ir;

	RegisterFile RegisterFile_inst (
		.clock    (clock),
		.rst      (rst),
		.irData   (ir),
		.gra      (gra),
		.grb      (grb),
		.grc      (grc),
		.rIn      (rIn),
		.rOut     (rOut),
		.baOut    (baOut),
		.jumpLink (jumpLink),
		.busIn    (bus),
		.regOut   (regOut)
	);

	Alu Alu_inst (
		.a      (ry),
		.b      (bus),
		.op     (aluOp),
		.incPc  (incPc),
		.result (aluResult)
	);

	BranchCondition BranchCondition_inst (
		.clock  (clock),
		.rst    (rst),
		.irData (ir),
		.bus    (bus),
		.conIn  (conIn),
		.conBit (conBit)
	);

endmodule

`default_nettype wire

/* datapath/BranchCondition.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module BranchCondition import cpuPkg::*; (
	input  logic                    clock,
	input  logic                    rst,
	input  instrWord_t              irData,
	input  logic [`DATA_WIDTH-1:0]  bus,
	input  logic                    conIn,
	output logic                    conBit
);

	brCond_t cond;
	logic    condMet;

	assign cond = brCond_t'(irData.iFormat.rbCond[1:0]);

	// Positive means strictly greater than zero
	always_comb begin
		case (cond)
			condZero:     condMet = (bus == '0);
			condNonzero:  condMet = (bus != '0);
			condPositive: condMet = !bus[`DATA_WIDTH-1] && (bus != '0);
			default:      condMet = bus[`DATA_WIDTH-1];
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			conBit <= 1'b0;
		end else if (conIn) begin
			conBit <= condMet;
		end
	end

endmodule

`default_nettype wire

/* datapath/Alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module Alu import cpuPkg::*; (
	input  logic [`DATA_WIDTH-1:0]    a,
	input  logic [`DATA_WIDTH-1:0]    b,
	input  opcode_t                   op,
	input  logic                      incPc,
	output logic [2*`DATA_WIDTH-1:0]  result
);

	logic [`DATA_WIDTH-1:0]           lowPart;
	logic signed [2*`DATA_WIDTH-1:0]  product;

	// Full signed product
	assign product = $signed(a) * $signed(b);

	always_comb begin
		// Add covers add, addi and address arithmetic
		lowPart = a + b;
		case (op)
			opSub: lowPart = a - b;
			opAnd: lowPart = a & b;
			opOr:  lowPart = a | b;
			opShl: lowPart = a << b[4:0];
			opShr: lowPart = a >> b[4:0];
			default: ;
		endcase

		// PC increment during fetch
		if (incPc) begin
			lowPart = b + 1'b1;
		end

		if (op == opMul && !incPc) begin
			result = product;
		end else begin
			result = {{`DATA_WIDTH{1'b0}}, lowPart};
		end
	end

endmodule

`default_nettype wire

/* datapath/RegisterFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module RegisterFile import cpuPkg::*; (
	input  logic                    clock,
	input  logic                    rst,
	input  instrWord_t              irData,
	input  logic                    gra,
	input  logic                    grb,
	input  logic                    grc,
	input  logic                    rIn,
	input  logic                    rOut,
	input  logic                    baOut,
	input  logic                    jumpLink,
	input  logic [`DATA_WIDTH-1:0]  busIn,
	output logic [`DATA_WIDTH-1:0]  regOut
);

	logic [`DATA_WIDTH-1:0] regs [16];
	logic [3:0]             sel;

	// Only one of gra/grb/grc is high in a step
	assign sel = ({4{gra}} & irData.rFormat.ra)
		| ({4{grb}} & irData.rFormat.rb)
		| ({4{grc}} & irData.rFormat.rc);

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (rIn) begin
				regs[sel] <= busIn;
			end
			// Link register, independent of the field select
			if (jumpLink) begin
				regs[15] <= busIn;
			end
		end
	end

	// R0 reads as zero when used as a base address
	always_comb begin
		if (!(rOut || baOut)) begin
			regOut = '0;
		end else if (baOut && sel == 4'd0) begin
			regOut = '0;
		end else begin
			regOut = regs[sel];
		end
	end

endmodule

`default_nettype wire

/* common/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	// Instruction class in IR[31:27]
	typedef enum logic [4:0] {
		opLd   = 5'd0,
		opLdi  = 5'd1,
		opSt   = 5'd2,
		opAdd  = 5'd3,
		opSub  = 5'd4,
		opAnd  = 5'd5,
		opOr   = 5'd6,
		opShl  = 5'd7,
		opShr  = 5'd8,
		opAddi = 5'd9,
		opMul  = 5'd10,
		opMfhi = 5'd11,
		opMflo = 5'd12,
		opBr   = 5'd13,
		opJal  = 5'd14,
		opJr   = 5'd15,
		opIn   = 5'd16,
		opOut  = 5'd17,
		opHalt = 5'd18
	} opcode_t;

	// Low two bits of the second register field in a branch
	typedef enum logic [1:0] {
		condZero     = 2'd0,
		condNonzero  = 2'd1,
		condPositive = 2'd2,
		condNegative = 2'd3
	} brCond_t;

	// Three register fields
	typedef struct packed {
		opcode_t     opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [14:0] unused;
	} rFormat_t;

	// Two register fields and a 19-bit constant
	typedef struct packed {
		opcode_t     opcode;
		logic [3:0]  ra;
		logic [3:0]  rbCond;
		logic [18:0] constant;
	} iFormat_t;

	typedef union packed {
		rFormat_t rFormat;
		iFormat_t iFormat;
	} instrWord_t;

endpackage

`default_nettype wire

/* common/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Width of the bus and of every register
`define DATA_WIDTH 32

// Program and data memory
`define MEM_DEPTH 512

// MAR low bits that reach the memory
`define ADDR_WIDTH 9

`endif
